// ==== hw/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    // transaction id width
    parameter int ID_W = 8;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // one strobe bit per data byte
    parameter int STRB_W = DATA_W / 8;

    // burst length field, 1 to 16 beats
    parameter int LEN_W = 4;

    // response codes
    parameter logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // default geometry
    parameter int NUM_BANKS_DEF  = 4;
    parameter int BANK_WORDS_DEF = 1024;

    // in-bank word index width
    function automatic int word_index_w(input int bank_words);
        return $clog2(bank_words);
    endfunction

    // bank select width of at least one bit
    function automatic int bank_sel_w(input int num_banks);
        return (num_banks > 1) ? $clog2(num_banks) : 1;
    endfunction

endpackage

`default_nettype wire

// ==== hw/axi_slave_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_slave_router #(
    parameter int NUM_BANKS  = mem_pkg::NUM_BANKS_DEF,
    parameter int BANK_WORDS = mem_pkg::BANK_WORDS_DEF
) (
    input  wire                                         ACLK,
    input  wire                                         ARESETn,
    input  wire  [axi_pkg::ADDR_W-1:0]                  awaddr,
    input  wire                                         awvalid,
    output logic                                        awready,
    input  wire  [axi_pkg::ADDR_W-1:0]                  araddr,
    input  wire                                         arvalid,
    output logic                                        arready,
    input  wire                                         wvalid,
    output logic                                        wready,
    input  wire                                         rvalid,
    input  wire                                         rready,
    input  wire                                         rlast,
    input  wire                                         bvalid,
    input  wire                                         bready,
    output logic [NUM_BANKS-1:0]                        bank_awvalid,
    input  wire  [NUM_BANKS-1:0]                        bank_awready,
    output logic [NUM_BANKS-1:0]                        bank_arvalid,
    input  wire  [NUM_BANKS-1:0]                        bank_arready,
    output logic [NUM_BANKS-1:0]                        bank_wvalid,
    input  wire  [NUM_BANKS-1:0]                        bank_wready,
    output logic [mem_pkg::bank_sel_w(NUM_BANKS)-1:0]   owner_sel
);

    localparam int SEL_W   = mem_pkg::bank_sel_w(NUM_BANKS);
    localparam int BANK_LO = $clog2(axi_pkg::STRB_W) + mem_pkg::word_index_w(BANK_WORDS);

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_write
    } state_t;

    state_t             state;
    logic [SEL_W-1:0]   aw_bank;
    logic [SEL_W-1:0]   ar_bank;
    logic               aw_hs;
    logic               ar_hs;

    // bank index sits just above the in-bank word index
    assign aw_bank = awaddr[BANK_LO +: SEL_W];
    assign ar_bank = araddr[BANK_LO +: SEL_W];

    // write address wins a tie with read address
    assign awready = (state == s_idle) && bank_awready[aw_bank];
    assign arready = (state == s_idle) && !awvalid && bank_arready[ar_bank];
    assign wready  = (state == s_write) && bank_wready[owner_sel];

    assign aw_hs = awvalid && awready;
    assign ar_hs = arvalid && arready;

    // only the addressed or owning bank sees a valid
    always_comb begin
        bank_awvalid = '0;
        bank_arvalid = '0;
        bank_wvalid  = '0;
        if (state == s_idle) begin
            bank_awvalid[aw_bank] = awvalid;
            bank_arvalid[ar_bank] = arvalid && !awvalid;
        end
        if (state == s_write) begin
            bank_wvalid[owner_sel] = wvalid;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state     <= s_idle;
            owner_sel <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (aw_hs) begin
                        state     <= s_write;
                        owner_sel <= aw_bank;
                    end else if (ar_hs) begin
                        state     <= s_read;
                        owner_sel <= ar_bank;
                    end
                end
                // free on the final beat seen at the port
                s_read: begin
                    if (rvalid && rready && rlast) begin
                        state <= s_idle;
                    end
                end
                s_write: begin
                    if (bvalid && bready) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/sram_bank_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_bank_slave #(
    parameter int BANK_WORDS = mem_pkg::BANK_WORDS_DEF
) (
    input  wire                         ACLK,
    input  wire                         ARESETn,
    input  wire  [axi_pkg::ID_W-1:0]    awid,
    input  wire  [axi_pkg::ADDR_W-1:0]  awaddr,
    input  wire  [axi_pkg::LEN_W-1:0]   awlen,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire  [axi_pkg::ID_W-1:0]    arid,
    input  wire  [axi_pkg::ADDR_W-1:0]  araddr,
    input  wire  [axi_pkg::LEN_W-1:0]   arlen,
    input  wire                         arvalid,
    output logic                        arready,
    input  wire  [axi_pkg::DATA_W-1:0]  wdata,
    input  wire  [axi_pkg::STRB_W-1:0]  wstrb,
    input  wire                         wlast,
    input  wire                         wvalid,
    output logic                        wready,
    output logic [axi_pkg::ID_W-1:0]    rid,
    output logic [axi_pkg::DATA_W-1:0]  rdata,
    output logic                        rlast,
    output logic                        rvalid,
    input  wire                         rready,
    output logic [axi_pkg::ID_W-1:0]    bid,
    output logic                        bvalid,
    input  wire                         bready
);

    localparam int IDX_W  = mem_pkg::word_index_w(BANK_WORDS);
    localparam int IDX_LO = $clog2(axi_pkg::STRB_W);

    typedef enum logic [1:0] {
        s_idle,
        s_read_data,
        s_write_data,
        s_write_resp
    } state_t;

    state_t                     state;
    logic [axi_pkg::LEN_W-1:0]  len;
    logic [axi_pkg::LEN_W-1:0]  beat;
    logic [IDX_W-1:0]           word_idx;
    logic [IDX_W-1:0]           aw_idx;
    logic [IDX_W-1:0]           ar_idx;
    logic                       aw_hs;
    logic                       ar_hs;
    logic                       w_hs;
    logic                       r_hs;
    logic                       w_done;

    logic [axi_pkg::DATA_W-1:0] mem [BANK_WORDS];

    assign aw_idx = awaddr[IDX_LO +: IDX_W];
    assign ar_idx = araddr[IDX_LO +: IDX_W];

    // handshake outputs straight from the state
    assign awready = (state == s_idle);
    assign arready = (state == s_idle) && !awvalid;
    assign wready  = (state == s_write_data);
    assign rvalid  = (state == s_read_data);
    assign bvalid  = (state == s_write_resp);
    assign rlast   = (state == s_read_data) && (beat == len);

    assign aw_hs = awvalid && awready;
    assign ar_hs = arvalid && arready;
    assign w_hs  = wvalid && wready;
    assign r_hs  = rvalid && rready;

    // close the write burst on wlast or on the awlen count
    assign w_done = w_hs && (wlast || (beat == len));

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= s_idle;
            beat  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    beat <= '0;
                    if (aw_hs) begin
                        state <= s_write_data;
                    end else if (ar_hs) begin
                        state <= s_read_data;
                    end
                end
                s_read_data: begin
                    if (r_hs) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            state <= s_idle;
                        end
                    end
                end
                s_write_data: begin
                    if (w_hs) begin
                        beat <= beat + 1'b1;
                    end
                    if (w_done) begin
                        state <= s_write_resp;
                    end
                end
                s_write_resp: begin
                    if (bready) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // request fields and the word pointer
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            bid      <= awid;
            len      <= awlen;
            word_idx <= aw_idx;
        end else if (ar_hs) begin
            rid      <= arid;
            len      <= arlen;
            word_idx <= ar_idx + 1'b1;
        end else if (w_hs || (r_hs && !rlast)) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // read one word ahead so the next beat is ready after each handshake
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            rdata <= mem[ar_idx];
        end else if (r_hs && !rlast) begin
            rdata <= mem[word_idx];
        end
    end

    // byte-masked write where bytes with a clear strobe keep their value
    always_ff @(posedge ACLK) begin
        if (w_hs) begin
            for (int b = 0; b < axi_pkg::STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/axi_response_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_response_merge #(
    parameter int NUM_BANKS = mem_pkg::NUM_BANKS_DEF
) (
    input  wire  [mem_pkg::bank_sel_w(NUM_BANKS)-1:0]       owner_sel,
    input  wire                                             rready,
    input  wire                                             bready,
    input  wire  [NUM_BANKS-1:0][axi_pkg::ID_W-1:0]         bank_rid,
    input  wire  [NUM_BANKS-1:0][axi_pkg::DATA_W-1:0]       bank_rdata,
    input  wire  [NUM_BANKS-1:0]                            bank_rlast,
    input  wire  [NUM_BANKS-1:0]                            bank_rvalid,
    input  wire  [NUM_BANKS-1:0][axi_pkg::ID_W-1:0]         bank_bid,
    input  wire  [NUM_BANKS-1:0]                            bank_bvalid,
    output logic [axi_pkg::ID_W-1:0]                        rid,
    output logic [axi_pkg::DATA_W-1:0]                      rdata,
    output logic [1:0]                                      rresp,
    output logic                                            rlast,
    output logic                                            rvalid,
    output logic [axi_pkg::ID_W-1:0]                        bid,
    output logic [1:0]                                      bresp,
    output logic                                            bvalid,
    output logic [NUM_BANKS-1:0]                            bank_rready,
    output logic [NUM_BANKS-1:0]                            bank_bready
);

    localparam int SEL_W = mem_pkg::bank_sel_w(NUM_BANKS);

    // owning bank drives the port
    assign rid    = bank_rid[owner_sel];
    assign rdata  = bank_rdata[owner_sel];
    assign rlast  = bank_rlast[owner_sel];
    assign rvalid = bank_rvalid[owner_sel];
    assign bid    = bank_bid[owner_sel];
    assign bvalid = bank_bvalid[owner_sel];

    // no error responses
    assign rresp = axi_pkg::RESP_OKAY;
    assign bresp = axi_pkg::RESP_OKAY;

    // ready goes back to the owner only
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_rready[i] = rready && (owner_sel == SEL_W'(i));
            bank_bready[i] = bready && (owner_sel == SEL_W'(i));
        end
    end

endmodule

`default_nettype wire

// ==== hw/sram_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_subsystem #(
    parameter int NUM_BANKS  = mem_pkg::NUM_BANKS_DEF,
    parameter int BANK_WORDS = mem_pkg::BANK_WORDS_DEF
) (
    input  wire                         ACLK,
    input  wire                         ARESETn,
    input  wire  [axi_pkg::ID_W-1:0]    awid,
    input  wire  [axi_pkg::ADDR_W-1:0]  awaddr,
    input  wire  [axi_pkg::LEN_W-1:0]   awlen,
    input  wire                         awvalid,
    output wire                         awready,
    input  wire  [axi_pkg::DATA_W-1:0]  wdata,
    input  wire  [axi_pkg::STRB_W-1:0]  wstrb,
    input  wire                         wlast,
    input  wire                         wvalid,
    output wire                         wready,
    output wire  [axi_pkg::ID_W-1:0]    bid,
    output wire  [1:0]                  bresp,
    output wire                         bvalid,
    input  wire                         bready,
    input  wire  [axi_pkg::ID_W-1:0]    arid,
    input  wire  [axi_pkg::ADDR_W-1:0]  araddr,
    input  wire  [axi_pkg::LEN_W-1:0]   arlen,
    input  wire                         arvalid,
    output wire                         arready,
    output wire  [axi_pkg::ID_W-1:0]    rid,
    output wire  [axi_pkg::DATA_W-1:0]  rdata,
    output wire  [1:0]                  rresp,
    output wire                         rlast,
    output wire                         rvalid,
    input  wire                         rready
);

    wire [NUM_BANKS-1:0]                        bank_awvalid;
    wire [NUM_BANKS-1:0]                        bank_awready;
    wire [NUM_BANKS-1:0]                        bank_arvalid;
    wire [NUM_BANKS-1:0]                        bank_arready;
    wire [NUM_BANKS-1:0]                        bank_wvalid;
    wire [NUM_BANKS-1:0]                        bank_wready;
    wire [NUM_BANKS-1:0][axi_pkg::ID_W-1:0]     bank_rid;
    wire [NUM_BANKS-1:0][axi_pkg::DATA_W-1:0]   bank_rdata;
    wire [NUM_BANKS-1:0]                        bank_rlast;
    wire [NUM_BANKS-1:0]                        bank_rvalid;
    wire [NUM_BANKS-1:0]                        bank_rready;
    wire [NUM_BANKS-1:0][axi_pkg::ID_W-1:0]     bank_bid;
    wire [NUM_BANKS-1:0]                        bank_bvalid;
    wire [NUM_BANKS-1:0]                        bank_bready;
    wire [mem_pkg::bank_sel_w(NUM_BANKS)-1:0]   owner_sel;

    axi_slave_router #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) i_axi_slave_router (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .wvalid       (wvalid),
        .wready       (wready),
        .rvalid       (rvalid),
        .rready       (rready),
        .rlast        (rlast),
        .bvalid       (bvalid),
        .bready       (bready),
        .bank_awvalid (bank_awvalid),
        .bank_awready (bank_awready),
        .bank_arvalid (bank_arvalid),
        .bank_arready (bank_arready),
        .bank_wvalid  (bank_wvalid),
        .bank_wready  (bank_wready),
        .owner_sel    (owner_sel)
    );

    // address and write data fields go to every bank while valids are per bank
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        sram_bank_slave #(
            .BANK_WORDS (BANK_WORDS)
        ) i_sram_bank_slave (
            .ACLK    (ACLK),
            .ARESETn (ARESETn),
            .awid    (awid),
            .awaddr  (awaddr),
            .awlen   (awlen),
            .awvalid (bank_awvalid[g]),
            .awready (bank_awready[g]),
            .arid    (arid),
            .araddr  (araddr),
            .arlen   (arlen),
            .arvalid (bank_arvalid[g]),
            .arready (bank_arready[g]),
            .wdata   (wdata),
            .wstrb   (wstrb),
            .wlast   (wlast),
            .wvalid  (bank_wvalid[g]),
            .wready  (bank_wready[g]),
            .rid     (bank_rid[g]),
            .rdata   (bank_rdata[g]),
            .rlast   (bank_rlast[g]),
            .rvalid  (bank_rvalid[g]),
            .rready  (bank_rready[g]),
            .bid     (bank_bid[g]),
            .bvalid  (bank_bvalid[g]),
            .bready  (bank_bready[g])
        );
    end

    axi_response_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) i_axi_response_merge (
        .owner_sel   (owner_sel),
        .rready      (rready),
        .bready      (bready),
        .bank_rid    (bank_rid),
        .bank_rdata  (bank_rdata),
        .bank_rlast  (bank_rlast),
        .bank_rvalid (bank_rvalid),
        .bank_bid    (bank_bid),
        .bank_bvalid (bank_bvalid),
        .rid         (rid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .bid         (bid),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bank_rready (bank_rready),
        .bank_bready (bank_bready)
    );

endmodule

`default_nettype wire

// ==== sim/sram_subsystem_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_subsystem_checker (
    input wire                          ACLK,
    input wire                          ARESETn,
    input wire                          awready,
    input wire                          arready,
    input wire                          wready,
    input wire                          rvalid,
    input wire                          rready,
    input wire  [axi_pkg::DATA_W-1:0]   rdata,
    input wire                          bvalid,
    input wire                          bready
);

    // read beat holds under back-pressure
    a_rvalid_hold: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (rvalid && !rready) |=> (rvalid && $stable(rdata))
    ) else $error("rvalid dropped or rdata changed while rready was low");

    a_bvalid_hold: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (bvalid && !bready) |=> bvalid
    ) else $error("bvalid dropped before bready");

    // one transaction at a time
    a_no_addr_when_busy: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (rvalid || bvalid || wready) |-> (!awready && !arready)
    ) else $error("address channel ready while a transaction is open");

endmodule

bind sram_subsystem sram_subsystem_checker i_sram_subsystem_checker (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .awready (awready),
    .arready (arready),
    .wready  (wready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .bvalid  (bvalid),
    .bready  (bready)
);

`default_nettype wire

// ==== sim/tb_tests.svh ====
// idle port right after reset
task automatic test_reset_values();
    @(negedge ACLK);
    check_value("reset_values", "awready", 32'd1, 32'(awready));
    check_value("reset_values", "arready", 32'd1, 32'(arready));
    check_value("reset_values", "wready", 32'd0, 32'(wready));
    check_value("reset_values", "rvalid", 32'd0, 32'(rvalid));
    check_value("reset_values", "bvalid", 32'd0, 32'(bvalid));
    @(posedge ACLK);
endtask

task automatic test_single_beat();
    logic [ADDR_W-1:0] addrs [NUM_BANKS];
    int                idx;
    // one index in every bank so that a bank decode fault aliases the words
    idx = int'($urandom % BANK_WORDS);
    for (int b = 0; b < NUM_BANKS; b++) begin
        addrs[b]     = word_addr(b, idx);
        wbuf_data[0] = $urandom;
        wbuf_strb[0] = '1;
        write_burst("single_beat", ID_W'(32'h10 + b), addrs[b], 1);
        read_burst("single_beat", ID_W'(32'h20 + b), addrs[b], 1, 1'b0);
    end
    // banks keep their own words
    for (int b = 0; b < NUM_BANKS; b++) begin
        read_burst("single_beat", ID_W'(32'h28 + b), addrs[b], 1, 1'b0);
    end
endtask

// incrementing data with rlast only on the final beat
task automatic test_burst();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] base;
    addr = word_addr(1, 100);
    base = $urandom;
    for (int i = 0; i < MAX_BEATS; i++) begin
        wbuf_data[i] = base + DATA_W'(i);
        wbuf_strb[i] = '1;
    end
    write_burst("burst16", 8'h31, addr, MAX_BEATS);
    read_burst("burst16", 8'h32, addr, MAX_BEATS, 1'b0);
endtask

task automatic test_partial_strobe();
    logic [ADDR_W-1:0] addr;
    addr = word_addr(2, 512);
    for (int i = 0; i < PARTIAL_WORDS; i++) begin
        wbuf_data[i] = 32'ha0b0c0d0 ^ (DATA_W'(i) * 32'h01010101);
        wbuf_strb[i] = '1;
    end
    write_burst("partial_strobe", 8'h40, addr, PARTIAL_WORDS);
    // first word gets an empty strobe and the rest random ones
    for (int i = 0; i < PARTIAL_WORDS; i++) begin
        wbuf_data[0] = $urandom;
        wbuf_strb[0] = (i == 0) ? '0 : STRB_W'($urandom);
        write_burst("partial_strobe", 8'h41, addr + ADDR_W'(i * STRB_W), 1);
    end
    read_burst("partial_strobe", 8'h42, addr, PARTIAL_WORDS, 1'b0);
endtask

task automatic test_read_backpressure();
    logic [ADDR_W-1:0] addr;
    addr = word_addr(3, 200);
    for (int i = 0; i < MAX_BEATS; i++) begin
        wbuf_data[i] = $urandom;
        wbuf_strb[i] = '1;
    end
    write_burst("read_backpressure", 8'h50, addr, MAX_BEATS);
    read_burst("read_backpressure", 8'h51, addr, MAX_BEATS, 1'b1);
endtask

// a read waits behind a write response that is held off
task automatic test_bresp_backpressure();
    logic [ADDR_W-1:0] addr;
    addr = word_addr(0, 7);
    wbuf_data[0] = $urandom;
    wbuf_strb[0] = '1;
    aw_request(8'h60, addr, 1);
    w_send(addr, 1);
    arid    <= 8'h61;
    araddr  <= addr;
    arlen   <= '0;
    arvalid <= 1'b1;
    for (int i = 0; i < BRESP_STALL; i++) begin
        @(negedge ACLK);
        check_value("bresp_backpressure", "bvalid held", 32'd1, 32'(bvalid));
        check_value("bresp_backpressure", "arready while b pending", 32'd0, 32'(arready));
        @(posedge ACLK);
    end
    b_collect("bresp_backpressure", 8'h60);
    @(negedge ACLK);
    check_value("bresp_backpressure", "arready after b handshake", 32'd1, 32'(arready));
    @(posedge ACLK);
    arvalid <= 1'b0;
    r_collect("bresp_backpressure", 8'h61, addr, 1, 1'b0);
endtask

// write wins the tie and the read then sees the new word
task automatic test_aw_ar_same_cycle();
    logic [ADDR_W-1:0] addr;
    addr = word_addr(1, 900);
    wbuf_data[0] = 32'h5a5a0f0f;
    wbuf_strb[0] = '1;
    write_burst("aw_ar_same_cycle", 8'h6f, addr, 1);
    wbuf_data[0] = ~(32'h5a5a0f0f) ^ $urandom;
    awid    <= 8'h70;
    awaddr  <= addr;
    awlen   <= '0;
    awvalid <= 1'b1;
    arid    <= 8'h71;
    araddr  <= addr;
    arlen   <= '0;
    arvalid <= 1'b1;
    @(negedge ACLK);
    check_value("aw_ar_same_cycle", "awready", 32'd1, 32'(awready));
    check_value("aw_ar_same_cycle", "arready", 32'd0, 32'(arready));
    @(posedge ACLK);
    awvalid <= 1'b0;
    w_send(addr, 1);
    b_collect("aw_ar_same_cycle", 8'h70);
    ar_request(8'h71, addr, 1);
    r_collect("aw_ar_same_cycle", 8'h71, addr, 1, 1'b0);
endtask

// ==== sim/tb_sram_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sram_subsystem;

    localparam int NUM_BANKS     = mem_pkg::NUM_BANKS_DEF;
    localparam int BANK_WORDS    = mem_pkg::BANK_WORDS_DEF;
    localparam int ID_W          = axi_pkg::ID_W;
    localparam int ADDR_W        = axi_pkg::ADDR_W;
    localparam int DATA_W        = axi_pkg::DATA_W;
    localparam int STRB_W        = axi_pkg::STRB_W;
    localparam int LEN_W         = axi_pkg::LEN_W;
    localparam int WORD_LO       = $clog2(STRB_W);
    localparam int IDX_W         = mem_pkg::word_index_w(BANK_WORDS);
    localparam int TOTAL_WORDS   = NUM_BANKS * BANK_WORDS;
    localparam int MAX_BEATS     = 16;
    localparam int PARTIAL_WORDS = 8;
    localparam int BRESP_STALL   = 6;
    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int SEED          = 32'h03c66d73;

    // beats of all tests in run order
    localparam int TOTAL_BEATS = 3 * NUM_BANKS + 2 * MAX_BEATS + 3 * PARTIAL_WORDS
                               + 2 * MAX_BEATS + 2 + 3;
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + RESET_CYCLES;

    logic                ACLK = 1'b0;
    logic                ARESETn;
    logic [ID_W-1:0]     awid;
    logic [ADDR_W-1:0]   awaddr;
    logic [LEN_W-1:0]    awlen;
    logic                awvalid;
    wire                 awready;
    logic [DATA_W-1:0]   wdata;
    logic [STRB_W-1:0]   wstrb;
    logic                wlast;
    logic                wvalid;
    wire                 wready;
    wire  [ID_W-1:0]     bid;
    wire  [1:0]          bresp;
    wire                 bvalid;
    logic                bready;
    logic [ID_W-1:0]     arid;
    logic [ADDR_W-1:0]   araddr;
    logic [LEN_W-1:0]    arlen;
    logic                arvalid;
    wire                 arready;
    wire  [ID_W-1:0]     rid;
    wire  [DATA_W-1:0]   rdata;
    wire  [1:0]          rresp;
    wire                 rlast;
    wire                 rvalid;
    logic                rready;

    // write beats staged by the tests
    logic [DATA_W-1:0]   wbuf_data [MAX_BEATS];
    logic [STRB_W-1:0]   wbuf_strb [MAX_BEATS];

    // expected memory contents with one entry per word of the subsystem
    logic [DATA_W-1:0]   model_mem [TOTAL_WORDS];

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    sram_subsystem #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) i_sram_subsystem (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // byte address of a word with the bank index above the in-bank index
    function automatic logic [ADDR_W-1:0] word_addr(input int bank, input int idx);
        return (ADDR_W'(bank) << (WORD_LO + IDX_W)) | (ADDR_W'(idx) << WORD_LO);
    endfunction

    function automatic int model_index(input logic [ADDR_W-1:0] addr);
        return int'(addr >> WORD_LO) % TOTAL_WORDS;
    endfunction

    // bytes with a set strobe take the new value
    function automatic logic [DATA_W-1:0] byte_merge(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] mask;
        for (int b = 0; b < STRB_W; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h",
                     test_name, field, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "%s stopped at the first mismatch", test_name);
        end
    endtask

    // driver tasks start and end just after a rising edge
    task automatic aw_request(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input int beats);
        logic accepted;
        awid    <= id;
        awaddr  <= addr;
        awlen   <= LEN_W'(beats - 1);
        awvalid <= 1'b1;
        do begin
            @(negedge ACLK);
            accepted = awready;
            @(posedge ACLK);
        end while (!accepted);
        awvalid <= 1'b0;
    endtask

    task automatic ar_request(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input int beats);
        logic accepted;
        arid    <= id;
        araddr  <= addr;
        arlen   <= LEN_W'(beats - 1);
        arvalid <= 1'b1;
        do begin
            @(negedge ACLK);
            accepted = arready;
            @(posedge ACLK);
        end while (!accepted);
        arvalid <= 1'b0;
    endtask

    task automatic w_send(input logic [ADDR_W-1:0] addr, input int beats);
        logic accepted;
        int   idx;
        idx = model_index(addr);
        for (int i = 0; i < beats; i++) begin
            wdata  <= wbuf_data[i];
            wstrb  <= wbuf_strb[i];
            wlast  <= (i == beats - 1);
            wvalid <= 1'b1;
            do begin
                @(negedge ACLK);
                accepted = wready;
                @(posedge ACLK);
            end while (!accepted);
            model_mem[idx + i] = byte_merge(model_mem[idx + i], wbuf_data[i], wbuf_strb[i]);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
    endtask

    task automatic b_collect(input string test_name, input logic [ID_W-1:0] id);
        logic done;
        bready <= 1'b1;
        do begin
            @(negedge ACLK);
            done = bvalid;
            if (done) begin
                check_value(test_name, "bid", 32'(id), 32'(bid));
                check_value(test_name, "bresp", 32'(axi_pkg::RESP_OKAY), 32'(bresp));
            end
            @(posedge ACLK);
        end while (!done);
        bready <= 1'b0;
    endtask

    // stall drops rready on about a third of the cycles
    task automatic r_collect(input string test_name, input logic [ID_W-1:0] id,
                             input logic [ADDR_W-1:0] addr, input int beats, input logic stall);
        int   idx;
        int   beat;
        logic done;
        idx  = model_index(addr);
        beat = 0;
        done = 1'b0;
        while (!done) begin
            if (stall) begin
                rready <= (($urandom % 3) != 0);
            end else begin
                rready <= 1'b1;
            end
            @(negedge ACLK);
            if (rvalid && rready) begin
                check_value(test_name, "rid", 32'(id), 32'(rid));
                check_value(test_name, "rresp", 32'(axi_pkg::RESP_OKAY), 32'(rresp));
                check_value(test_name, $sformatf("rdata beat %0d", beat),
                            model_mem[idx + beat], rdata);
                check_value(test_name, $sformatf("rlast beat %0d", beat),
                            32'(beat == beats - 1), 32'(rlast));
                done = rlast;
                beat++;
            end
            @(posedge ACLK);
        end
        rready <= 1'b0;
    endtask

    task automatic write_burst(input string test_name, input logic [ID_W-1:0] id,
                               input logic [ADDR_W-1:0] addr, input int beats);
        aw_request(id, addr, beats);
        w_send(addr, beats);
        b_collect(test_name, id);
    endtask

    task automatic read_burst(input string test_name, input logic [ID_W-1:0] id,
                              input logic [ADDR_W-1:0] addr, input int beats,
                              input logic stall);
        ar_request(id, addr, beats);
        r_collect(test_name, id, addr, beats, stall);
    endtask

    `include "tb_tests.svh"

    initial begin
        void'($urandom(SEED));
        ARESETn = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge ACLK);
        ARESETn <= 1'b1;
        @(posedge ACLK);

        test_reset_values();
        test_single_beat();
        test_burst();
        test_partial_strobe();
        test_read_backpressure();
        test_bresp_backpressure();
        test_aw_ar_same_cycle();

        $display("*** PASSED ***");
        $finish;
    end

    // bounded by the beat count of all tests
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge ACLK);
        $display("*** FAILED ***");
        $fatal(1, "timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+sim
hw/axi_pkg.sv
hw/mem_pkg.sv
hw/axi_slave_router.sv
hw/sram_bank_slave.sv
hw/axi_response_merge.sv
hw/sram_subsystem.sv
sim/sram_subsystem_checker.sv
sim/tb_sram_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the SRAM subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_subsystem
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard sim/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
